// File: verilog/rename_settings.svh
// Rename stage sizes
// Group width, register file sizes and checkpoint depth

`ifndef RENAME_SETTINGS_SVH
`define RENAME_SETTINGS_SVH

// Micro-ops renamed per group
`define RENAME_WIDTH 4

// Architectural register file
`define ARCH_REG_NUM 32

// Physical register file, the free list holds the surplus
`define PHYS_REG_NUM 64

// Branch checkpoints in flight
`define CHECKPOINT_NUM 4

`endif

// File: verilog/rename_pkg.sv
// Rename stage types
// Register numbers, checkpoint index, slot mask and micro-op kind

`include "rename_settings.svh"

package rename_pkg;

  // Architectural register number
  typedef logic [$clog2(`ARCH_REG_NUM)-1:0] areg_t;

  // Physical register number
  typedef logic [$clog2(`PHYS_REG_NUM)-1:0] preg_t;

  // Index into the checkpoint FIFO
  typedef logic [$clog2(`CHECKPOINT_NUM)-1:0] ckpt_id_t;

  // One bit per slot of a group
  typedef logic [`RENAME_WIDTH-1:0] slot_mask_t;

  // Slot kind
  // ALU writes a destination, BRANCH takes a checkpoint only
  typedef enum logic [1:0] {
    UOP_NOP    = 2'd0,
    UOP_ALU    = 2'd1,
    UOP_BRANCH = 2'd2
  } uop_kind_e;

endpackage

// File: verilog/rename_intake.sv
// Rename intake
// Holds one incoming group and fires it when pregs and checkpoints allow

`include "rename_settings.svh"

module rename_intake (
  input  logic                                       clk,
  input  logic                                       s_rst_n,
  input  logic                                       group_valid_i,
  input  rename_pkg::uop_kind_e [`RENAME_WIDTH-1:0]  kind_i,
  input  rename_pkg::areg_t [`RENAME_WIDTH-1:0]      src0_i,
  input  rename_pkg::areg_t [`RENAME_WIDTH-1:0]      src1_i,
  input  rename_pkg::areg_t [`RENAME_WIDTH-1:0]      dest_i,
  input  logic [$clog2(`PHYS_REG_NUM)-1:0]           free_count_i,
  input  logic                                       ckpt_full_i,
  input  logic                                       flush_i,
  output logic                                       stall_o,
  output logic                                       fire_o,
  output logic                                       hold_valid_o,
  output rename_pkg::uop_kind_e [`RENAME_WIDTH-1:0]  hold_kind_o,
  output rename_pkg::areg_t [`RENAME_WIDTH-1:0]      hold_src0_o,
  output rename_pkg::areg_t [`RENAME_WIDTH-1:0]      hold_src1_o,
  output rename_pkg::areg_t [`RENAME_WIDTH-1:0]      hold_dest_o,
  output rename_pkg::slot_mask_t                     hold_write_o
);
  import rename_pkg::*;

  slot_mask_t                       hold_branch;
  slot_mask_t                       in_branch;
  logic [$clog2(`RENAME_WIDTH):0]   write_cnt;
  logic                             take;

  // Writing slots and branch slots of the held group
  always_comb begin
    write_cnt = '0;
    for (int i = 0; i < `RENAME_WIDTH; i++) begin
      hold_write_o[i] = hold_valid_o && (hold_kind_o[i] == UOP_ALU);
      hold_branch[i]  = hold_valid_o && (hold_kind_o[i] == UOP_BRANCH);
      in_branch[i]    = kind_i[i] == UOP_BRANCH;
      write_cnt       = write_cnt + {{$clog2(`RENAME_WIDTH){1'b0}}, hold_write_o[i]};
    end
  end

  // Enough pregs, and a free checkpoint if a branch is present
  assign fire_o  = hold_valid_o && (free_count_i >= write_cnt) &&
                   (!(|hold_branch) || !ckpt_full_i) && !flush_i;
  assign stall_o = hold_valid_o && !fire_o;
  assign take    = group_valid_i && !stall_o && !flush_i;

  always_ff @(posedge clk or negedge s_rst_n) begin
    if (!s_rst_n) begin
      hold_valid_o <= 1'b0;
    end else if (flush_i) begin
      hold_valid_o <= 1'b0;
    end else if (take) begin
      hold_valid_o <= 1'b1;
    end else if (fire_o) begin
      hold_valid_o <= 1'b0;
    end
  end

  // Group payload
  always_ff @(posedge clk) begin
    if (take) begin
      hold_kind_o <= kind_i;
      hold_src0_o <= src0_i;
      hold_src1_o <= src1_i;
      hold_dest_o <= dest_i;
    end
  end

  // Checkpoint state only covers one branch per group
  a_one_branch: assert property (@(posedge clk) disable iff (!s_rst_n)
    take |-> $countones(in_branch) <= 1);

endmodule

// File: verilog/free_list.sv
// Free list
// Circular FIFO of free pregs, allocates at the head, takes commits
// at the tail, and rewinds the head from a branch checkpoint

`include "rename_settings.svh"

module free_list (
  input  logic                                   clk,
  input  logic                                   s_rst_n,
  input  rename_pkg::slot_mask_t                 write_mask_i,
  input  logic                                   fire_i,
  output rename_pkg::preg_t [`RENAME_WIDTH-1:0]  alloc_preg_o,
  output logic [$clog2(`PHYS_REG_NUM)-1:0]       free_count_o,
  input  rename_pkg::slot_mask_t                 commit_valid_i,
  input  rename_pkg::preg_t [`RENAME_WIDTH-1:0]  commit_preg_i,
  input  logic                                   ckpt_take_i,
  input  rename_pkg::slot_mask_t                 ckpt_slot_i,
  input  rename_pkg::ckpt_id_t                   ckpt_id_i,
  input  logic                                   restore_i,
  input  rename_pkg::ckpt_id_t                   restore_id_i
);
  import rename_pkg::*;

  localparam int FL_DEPTH = `PHYS_REG_NUM - `ARCH_REG_NUM;
  localparam int IDX_W    = $clog2(FL_DEPTH);
  localparam int PTR_W    = IDX_W + 1;
  localparam int CNT_W    = $clog2(`PHYS_REG_NUM);
  localparam int OFF_W    = $clog2(`RENAME_WIDTH) + 1;

  preg_t             fl_mem [FL_DEPTH];
  logic [PTR_W-1:0]  head_q;
  logic [PTR_W-1:0]  tail_q;
  logic [PTR_W-1:0]  ckpt_head_q [`CHECKPOINT_NUM];
  logic [PTR_W-1:0]  count;
  logic [OFF_W-1:0]  alloc_off [`RENAME_WIDTH+1];
  logic [OFF_W-1:0]  commit_off [`RENAME_WIDTH+1];
  logic [OFF_W-1:0]  branch_off;

  // ==============================
  // Slot offsets
  // ==============================
  // Running count of writers and commits ahead of each slot
  always_comb begin
    alloc_off[0]  = '0;
    commit_off[0] = '0;
    branch_off    = '0;
    for (int i = 0; i < `RENAME_WIDTH; i++) begin
      alloc_off[i+1]  = alloc_off[i] + OFF_W'(write_mask_i[i]);
      commit_off[i+1] = commit_off[i] + OFF_W'(commit_valid_i[i]);
      if (ckpt_slot_i[i]) begin
        branch_off = alloc_off[i];
      end
    end
  end

  // Writing slots take the entries at the head in slot order
  always_comb begin
    for (int i = 0; i < `RENAME_WIDTH; i++) begin
      alloc_preg_o[i] = fl_mem[head_q[IDX_W-1:0] + IDX_W'(alloc_off[i])];
    end
  end

  // Wrap bit makes a full list distinct from an empty one
  assign count        = tail_q - head_q;
  assign free_count_o = CNT_W'(count);

  // ==============================
  // Pointers and storage
  // ==============================
  // Reset content is pregs ARCH_REG_NUM and up, list full
  always_ff @(posedge clk or negedge s_rst_n) begin
    if (!s_rst_n) begin
      for (int i = 0; i < FL_DEPTH; i++) begin
        fl_mem[i] <= preg_t'(`ARCH_REG_NUM + i);
      end
      head_q <= '0;
      tail_q <= PTR_W'(FL_DEPTH);
    end else begin
      // Commits append in slot order
      for (int i = 0; i < `RENAME_WIDTH; i++) begin
        if (commit_valid_i[i]) begin
          fl_mem[tail_q[IDX_W-1:0] + IDX_W'(commit_off[i])] <= commit_preg_i[i];
        end
      end
      tail_q <= tail_q + PTR_W'(commit_off[`RENAME_WIDTH]);
      if (restore_i) begin
        head_q <= ckpt_head_q[restore_id_i];
      end else if (fire_i) begin
        head_q <= head_q + PTR_W'(alloc_off[`RENAME_WIDTH]);
      end
    end
  end

  // Head as it stands right after the branch slot
  always_ff @(posedge clk) begin
    if (ckpt_take_i) begin
      ckpt_head_q[ckpt_id_i] <= head_q + PTR_W'(branch_off);
    end
  end

  // Commits never return more pregs than were handed out
  a_count_bound: assert property (@(posedge clk) disable iff (!s_rst_n)
    count <= PTR_W'(FL_DEPTH));

endmodule

// File: verilog/register_alias_table.sv
// Register alias table
// Maps architectural to physical registers with in-group forwarding,
// keeps a FIFO of branch checkpoints and restores on a mispredict

`include "rename_settings.svh"

module register_alias_table (
  input  logic                                       clk,
  input  logic                                       s_rst_n,
  input  logic                                       fire_i,
  input  rename_pkg::uop_kind_e [`RENAME_WIDTH-1:0]  kind_i,
  input  rename_pkg::areg_t [`RENAME_WIDTH-1:0]      src0_i,
  input  rename_pkg::areg_t [`RENAME_WIDTH-1:0]      src1_i,
  input  rename_pkg::areg_t [`RENAME_WIDTH-1:0]      dest_i,
  input  rename_pkg::slot_mask_t                     write_mask_i,
  input  rename_pkg::preg_t [`RENAME_WIDTH-1:0]      preg_i,
  input  logic                                       resolve_i,
  input  logic                                       mispredict_i,
  output rename_pkg::preg_t [`RENAME_WIDTH-1:0]      psrc0_o,
  output rename_pkg::preg_t [`RENAME_WIDTH-1:0]      psrc1_o,
  output rename_pkg::preg_t [`RENAME_WIDTH-1:0]      ppdst_o,
  output rename_pkg::ckpt_id_t                       ckpt_o,
  output logic                                       ckpt_full_o,
  output logic                                       ckpt_take_o,
  output rename_pkg::slot_mask_t                     ckpt_slot_o,
  output logic                                       restore_o,
  output rename_pkg::ckpt_id_t                       restore_id_o
);
  import rename_pkg::*;

  localparam int CNT_W = $clog2(`CHECKPOINT_NUM) + 1;

  preg_t             rat_q [`ARCH_REG_NUM];
  preg_t             slot_map [`RENAME_WIDTH][`ARCH_REG_NUM];
  preg_t             snap_map [`ARCH_REG_NUM];
  preg_t             ckpt_map_q [`CHECKPOINT_NUM][`ARCH_REG_NUM];
  ckpt_id_t          ckpt_head_q;
  ckpt_id_t          ckpt_tail_q;
  logic [CNT_W-1:0]  ckpt_cnt_q;
  slot_mask_t        branch_mask;
  slot_mask_t        last_write;

  // ==============================
  // Lookup and forwarding
  // ==============================
  always_comb begin
    for (int i = 0; i < `RENAME_WIDTH; i++) begin
      psrc0_o[i] = rat_q[src0_i[i]];
      psrc1_o[i] = rat_q[src1_i[i]];
      ppdst_o[i] = rat_q[dest_i[i]];
      // Later j overrides, so the newest earlier writer wins
      for (int j = 0; j < i; j++) begin
        if (write_mask_i[j] && (dest_i[j] == src0_i[i])) psrc0_o[i] = preg_i[j];
        if (write_mask_i[j] && (dest_i[j] == src1_i[i])) psrc1_o[i] = preg_i[j];
        if (write_mask_i[j] && (dest_i[j] == dest_i[i])) ppdst_o[i] = preg_i[j];
      end
    end
  end

  // WAW, a writer drops out when a younger slot hits the same dest
  always_comb begin
    for (int i = 0; i < `RENAME_WIDTH; i++) begin
      last_write[i]  = write_mask_i[i];
      branch_mask[i] = kind_i[i] == UOP_BRANCH;
      for (int j = i + 1; j < `RENAME_WIDTH; j++) begin
        if (write_mask_i[j] && (dest_i[j] == dest_i[i])) last_write[i] = 1'b0;
      end
    end
  end

  // Table state after each slot, snapshot taken at the branch slot
  always_comb begin
    preg_t map [`ARCH_REG_NUM];
    map = rat_q;
    for (int i = 0; i < `RENAME_WIDTH; i++) begin
      if (write_mask_i[i]) map[dest_i[i]] = preg_i[i];
      slot_map[i] = map;
    end
    snap_map = slot_map[`RENAME_WIDTH-1];
    for (int i = 0; i < `RENAME_WIDTH; i++) begin
      if (branch_mask[i]) snap_map = slot_map[i];
    end
  end

  // ==============================
  // Checkpoint FIFO control
  // ==============================
  assign ckpt_take_o  = fire_i && (|branch_mask);
  assign ckpt_slot_o  = branch_mask;
  assign ckpt_o       = ckpt_tail_q;
  assign ckpt_full_o  = ckpt_cnt_q == CNT_W'(`CHECKPOINT_NUM);
  assign restore_o    = resolve_i && mispredict_i;
  assign restore_id_o = ckpt_head_q;

  // Mapping table, identity after reset
  always_ff @(posedge clk or negedge s_rst_n) begin
    if (!s_rst_n) begin
      for (int i = 0; i < `ARCH_REG_NUM; i++) begin
        rat_q[i] <= preg_t'(i);
      end
    end else if (restore_o) begin
      rat_q <= ckpt_map_q[ckpt_head_q];
    end else if (fire_i) begin
      for (int i = 0; i < `RENAME_WIDTH; i++) begin
        if (last_write[i]) rat_q[dest_i[i]] <= preg_i[i];
      end
    end
  end

  // Oldest checkpoint at the head, mispredict empties the FIFO
  always_ff @(posedge clk or negedge s_rst_n) begin
    if (!s_rst_n) begin
      ckpt_head_q <= '0;
      ckpt_tail_q <= '0;
      ckpt_cnt_q  <= '0;
    end else if (restore_o) begin
      ckpt_tail_q <= ckpt_head_q;
      ckpt_cnt_q  <= '0;
    end else begin
      if (ckpt_take_o) ckpt_tail_q <= ckpt_tail_q + 1'b1;
      if (resolve_i) ckpt_head_q <= ckpt_head_q + 1'b1;
      ckpt_cnt_q <= ckpt_cnt_q + CNT_W'(ckpt_take_o) - CNT_W'(resolve_i);
    end
  end

  always_ff @(posedge clk) begin
    if (ckpt_take_o) begin
      ckpt_map_q[ckpt_tail_q] <= snap_map;
    end
  end

  // Resolves only target an outstanding branch
  a_resolve_pending: assert property (@(posedge clk) disable iff (!s_rst_n)
    resolve_i |-> ckpt_cnt_q != '0);

endmodule

// File: verilog/rename_output.sv
// Rename output register
// Holds the renamed group for one cycle towards dispatch and the ROB

`include "rename_settings.svh"

module rename_output (
  input  logic                                       clk,
  input  logic                                       s_rst_n,
  input  logic                                       fire_i,
  input  logic                                       flush_i,
  input  rename_pkg::uop_kind_e [`RENAME_WIDTH-1:0]  kind_i,
  input  rename_pkg::preg_t [`RENAME_WIDTH-1:0]      psrc0_i,
  input  rename_pkg::preg_t [`RENAME_WIDTH-1:0]      psrc1_i,
  input  rename_pkg::preg_t [`RENAME_WIDTH-1:0]      pdst_i,
  input  rename_pkg::preg_t [`RENAME_WIDTH-1:0]      ppdst_i,
  input  rename_pkg::ckpt_id_t                       ckpt_i,
  output logic                                       out_valid_o,
  output rename_pkg::uop_kind_e [`RENAME_WIDTH-1:0]  out_kind_o,
  output rename_pkg::preg_t [`RENAME_WIDTH-1:0]      psrc0_o,
  output rename_pkg::preg_t [`RENAME_WIDTH-1:0]      psrc1_o,
  output rename_pkg::preg_t [`RENAME_WIDTH-1:0]      pdst_o,
  output rename_pkg::preg_t [`RENAME_WIDTH-1:0]      ppdst_o,
  output rename_pkg::ckpt_id_t                       out_ckpt_o
);
  import rename_pkg::*;

  // One-cycle valid, dropped on a mispredict
  always_ff @(posedge clk or negedge s_rst_n) begin
    if (!s_rst_n) begin
      out_valid_o <= 1'b0;
    end else if (flush_i) begin
      out_valid_o <= 1'b0;
    end else begin
      out_valid_o <= fire_i;
    end
  end

  always_ff @(posedge clk) begin
    if (fire_i) begin
      out_kind_o <= kind_i;
      psrc0_o    <= psrc0_i;
      psrc1_o    <= psrc1_i;
      ppdst_o    <= ppdst_i;
      out_ckpt_o <= ckpt_i;
      // Only writers own an allocated preg
      for (int i = 0; i < `RENAME_WIDTH; i++) begin
        pdst_o[i] <= (kind_i[i] == UOP_ALU) ? pdst_i[i] : '0;
      end
    end
  end

endmodule

// File: verilog/rename_top.sv
// Register rename stage
// Intake, free list, alias table and output register

`include "rename_settings.svh"

module rename_top (
  input  logic                                       clk,
  input  logic                                       s_rst_n,
  input  logic                                       group_valid_i,
  input  rename_pkg::uop_kind_e [`RENAME_WIDTH-1:0]  kind_i,
  input  rename_pkg::areg_t [`RENAME_WIDTH-1:0]      src0_i,
  input  rename_pkg::areg_t [`RENAME_WIDTH-1:0]      src1_i,
  input  rename_pkg::areg_t [`RENAME_WIDTH-1:0]      dest_i,
  input  rename_pkg::slot_mask_t                     commit_valid_i,
  input  rename_pkg::preg_t [`RENAME_WIDTH-1:0]      commit_preg_i,
  input  logic                                       resolve_i,
  input  logic                                       mispredict_i,
  output logic                                       stall_o,
  output logic                                       out_valid_o,
  output rename_pkg::uop_kind_e [`RENAME_WIDTH-1:0]  out_kind_o,
  output rename_pkg::preg_t [`RENAME_WIDTH-1:0]      psrc0_o,
  output rename_pkg::preg_t [`RENAME_WIDTH-1:0]      psrc1_o,
  output rename_pkg::preg_t [`RENAME_WIDTH-1:0]      pdst_o,
  output rename_pkg::preg_t [`RENAME_WIDTH-1:0]      ppdst_o,
  output rename_pkg::ckpt_id_t                       out_ckpt_o
);
  import rename_pkg::*;

  logic                                fire;
  uop_kind_e [`RENAME_WIDTH-1:0]       hold_kind;
  areg_t [`RENAME_WIDTH-1:0]           hold_src0;
  areg_t [`RENAME_WIDTH-1:0]           hold_src1;
  areg_t [`RENAME_WIDTH-1:0]           hold_dest;
  slot_mask_t                          hold_write;
  logic [$clog2(`PHYS_REG_NUM)-1:0]    free_count;
  preg_t [`RENAME_WIDTH-1:0]           alloc_preg;
  preg_t [`RENAME_WIDTH-1:0]           rat_psrc0;
  preg_t [`RENAME_WIDTH-1:0]           rat_psrc1;
  preg_t [`RENAME_WIDTH-1:0]           rat_ppdst;
  ckpt_id_t                            ckpt_id;
  logic                                ckpt_full;
  logic                                ckpt_take;
  slot_mask_t                          ckpt_slot;
  logic                                restore;
  ckpt_id_t                            restore_id;

  // ==============================
  // Input side
  // ==============================
  rename_intake rename_intake_i (
    .clk           (clk),
    .s_rst_n       (s_rst_n),
    .group_valid_i (group_valid_i),
    .kind_i        (kind_i),
    .src0_i        (src0_i),
    .src1_i        (src1_i),
    .dest_i        (dest_i),
    .free_count_i  (free_count),
    .ckpt_full_i   (ckpt_full),
    .flush_i       (restore),
    .stall_o       (stall_o),
    .fire_o        (fire),
    .hold_valid_o  (),
    .hold_kind_o   (hold_kind),
    .hold_src0_o   (hold_src0),
    .hold_src1_o   (hold_src1),
    .hold_dest_o   (hold_dest),
    .hold_write_o  (hold_write)
  );

  free_list free_list_i (
    .clk            (clk),
    .s_rst_n        (s_rst_n),
    .write_mask_i   (hold_write),
    .fire_i         (fire),
    .alloc_preg_o   (alloc_preg),
    .free_count_o   (free_count),
    .commit_valid_i (commit_valid_i),
    .commit_preg_i  (commit_preg_i),
    .ckpt_take_i    (ckpt_take),
    .ckpt_slot_i    (ckpt_slot),
    .ckpt_id_i      (ckpt_id),
    .restore_i      (restore),
    .restore_id_i   (restore_id)
  );

  register_alias_table register_alias_table_i (
    .clk          (clk),
    .s_rst_n      (s_rst_n),
    .fire_i       (fire),
    .kind_i       (hold_kind),
    .src0_i       (hold_src0),
    .src1_i       (hold_src1),
    .dest_i       (hold_dest),
    .write_mask_i (hold_write),
    .preg_i       (alloc_preg),
    .resolve_i    (resolve_i),
    .mispredict_i (mispredict_i),
    .psrc0_o      (rat_psrc0),
    .psrc1_o      (rat_psrc1),
    .ppdst_o      (rat_ppdst),
    .ckpt_o       (ckpt_id),
    .ckpt_full_o  (ckpt_full),
    .ckpt_take_o  (ckpt_take),
    .ckpt_slot_o  (ckpt_slot),
    .restore_o    (restore),
    .restore_id_o (restore_id)
  );

  // ==============================
  // Output side
  // ==============================
  rename_output rename_output_i (
    .clk         (clk),
    .s_rst_n     (s_rst_n),
    .fire_i      (fire),
    .flush_i     (restore),
    .kind_i      (hold_kind),
    .psrc0_i     (rat_psrc0),
    .psrc1_i     (rat_psrc1),
    .pdst_i      (alloc_preg),
    .ppdst_i     (rat_ppdst),
    .ckpt_i      (ckpt_id),
    .out_valid_o (out_valid_o),
    .out_kind_o  (out_kind_o),
    .psrc0_o     (psrc0_o),
    .psrc1_o     (psrc1_o),
    .pdst_o      (pdst_o),
    .ppdst_o     (ppdst_o),
    .out_ckpt_o  (out_ckpt_o)
  );

endmodule

// File: bench/rename_tb.sv
// Rename stage testbench
// Directed and random groups checked against a model of the alias
// table, the free list and the branch checkpoints

`include "rename_settings.svh"

module rename_tb;
  import rename_pkg::*;

  localparam int NW       = `RENAME_WIDTH;
  localparam int NCK      = `CHECKPOINT_NUM;
  localparam int FL_DEPTH = `PHYS_REG_NUM - `ARCH_REG_NUM;
  localparam int TIMEOUT  = 64;

  logic                       clk;
  logic                       s_rst_n;
  logic                       group_valid_i;
  uop_kind_e [NW-1:0]         kind_i;
  areg_t [NW-1:0]             src0_i;
  areg_t [NW-1:0]             src1_i;
  areg_t [NW-1:0]             dest_i;
  slot_mask_t                 commit_valid_i;
  preg_t [NW-1:0]             commit_preg_i;
  logic                       resolve_i;
  logic                       mispredict_i;
  logic                       stall_o;
  logic                       out_valid_o;
  uop_kind_e [NW-1:0]         out_kind_o;
  preg_t [NW-1:0]             psrc0_o;
  preg_t [NW-1:0]             psrc1_o;
  preg_t [NW-1:0]             pdst_o;
  preg_t [NW-1:0]             ppdst_o;
  ckpt_id_t                   out_ckpt_o;

  // ==============================
  // Model state
  // ==============================
  preg_t  tbl [`ARCH_REG_NUM];
  preg_t  fl [$];
  // Old mappings waiting for commit, oldest first
  preg_t  retire_q [$];
  int     pushed_total;
  int     popped_total;
  // Checkpoint ring, slot index is the checkpoint id
  preg_t  ck_tbl [NCK][`ARCH_REG_NUM];
  preg_t  ck_fl [NCK][FL_DEPTH];
  int     ck_fl_n [NCK];
  int     ck_mark [NCK];
  int     ck_head;
  int     ck_tail;
  int     ck_cnt;

  // Group in flight and its expected results
  uop_kind_e [NW-1:0]  pend_kind;
  areg_t [NW-1:0]      pend_src0;
  areg_t [NW-1:0]      pend_src1;
  areg_t [NW-1:0]      pend_dest;
  preg_t               exp_src0 [NW];
  preg_t               exp_src1 [NW];
  preg_t               exp_pdst [NW];
  preg_t               exp_ppdst [NW];
  ckpt_id_t            exp_ckpt;

  rename_top rename_top_i (
    .clk            (clk),
    .s_rst_n        (s_rst_n),
    .group_valid_i  (group_valid_i),
    .kind_i         (kind_i),
    .src0_i         (src0_i),
    .src1_i         (src1_i),
    .dest_i         (dest_i),
    .commit_valid_i (commit_valid_i),
    .commit_preg_i  (commit_preg_i),
    .resolve_i      (resolve_i),
    .mispredict_i   (mispredict_i),
    .stall_o        (stall_o),
    .out_valid_o    (out_valid_o),
    .out_kind_o     (out_kind_o),
    .psrc0_o        (psrc0_o),
    .psrc1_o        (psrc1_o),
    .pdst_o         (pdst_o),
    .ppdst_o        (ppdst_o),
    .out_ckpt_o     (out_ckpt_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ==============================
  // Checks
  // ==============================
  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("test failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_preg(input string name, input preg_t got, input preg_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_ckpt(input string name, input ckpt_id_t got, input ckpt_id_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_kind(input string name, input uop_kind_e got, input uop_kind_e exp);
    if (got !== exp) begin
      stop_on_error($sformatf("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  // ==============================
  // Model updates
  // ==============================
  // Walk the slots in order, so forwarding and last-writer-wins fall out
  task automatic model_rename();
    preg_t work [`ARCH_REG_NUM];
    work     = tbl;
    exp_ckpt = ckpt_id_t'(ck_tail);
    for (int i = 0; i < NW; i++) begin
      exp_src0[i]  = work[pend_src0[i]];
      exp_src1[i]  = work[pend_src1[i]];
      exp_ppdst[i] = work[pend_dest[i]];
      exp_pdst[i]  = '0;
      if (pend_kind[i] == UOP_ALU) begin
        exp_pdst[i] = fl.pop_front();
        work[pend_dest[i]] = exp_pdst[i];
        retire_q.push_back(exp_ppdst[i]);
        pushed_total++;
      end else if (pend_kind[i] == UOP_BRANCH) begin
        // State just after the branch slot
        ck_tbl[ck_tail] = work;
        foreach (fl[k]) ck_fl[ck_tail][k] = fl[k];
        ck_fl_n[ck_tail] = fl.size();
        ck_mark[ck_tail] = pushed_total;
        ck_tail = (ck_tail + 1) % NCK;
        ck_cnt++;
      end
    end
    tbl = work;
  endtask

  // ==============================
  // Stimulus
  // ==============================
  task automatic clear_group();
    for (int i = 0; i < NW; i++) begin
      pend_kind[i] = UOP_NOP;
      pend_src0[i] = '0;
      pend_src1[i] = '0;
      pend_dest[i] = '0;
    end
  endtask

  task automatic set_slot(input int i, input uop_kind_e k, input int s0, input int s1,
                          input int d);
    pend_kind[i] = k;
    pend_src0[i] = areg_t'(s0);
    pend_src1[i] = areg_t'(s1);
    pend_dest[i] = areg_t'(d);
  endtask

  // Present the pending group until the stage takes it
  task automatic issue_group();
    int waited;
    waited = 0;
    @(negedge clk);
    group_valid_i = 1'b1;
    kind_i        = pend_kind;
    src0_i        = pend_src0;
    src1_i        = pend_src1;
    dest_i        = pend_dest;
    while (stall_o) begin
      if (waited == TIMEOUT) begin
        stop_on_error("Timeout while waiting for stall_o to drop");
      end else begin
        @(negedge clk);
        waited++;
      end
    end
    @(posedge clk);
    @(negedge clk);
    group_valid_i = 1'b0;
  endtask

  // Wait for the renamed group, then compare every slot
  task automatic expect_group();
    int waited;
    waited = 0;
    while (!out_valid_o) begin
      if (waited == TIMEOUT) begin
        stop_on_error("Timeout while waiting for out_valid_o");
      end else begin
        @(negedge clk);
        waited++;
      end
    end
    model_rename();
    for (int i = 0; i < NW; i++) begin
      check_kind($sformatf("out_kind_o[%0d]", i), out_kind_o[i], pend_kind[i]);
      check_preg($sformatf("psrc0_o[%0d]", i), psrc0_o[i], exp_src0[i]);
      check_preg($sformatf("psrc1_o[%0d]", i), psrc1_o[i], exp_src1[i]);
      check_preg($sformatf("pdst_o[%0d]", i), pdst_o[i], exp_pdst[i]);
      if (pend_kind[i] == UOP_ALU) begin
        check_preg($sformatf("ppdst_o[%0d]", i), ppdst_o[i], exp_ppdst[i]);
      end
      if (pend_kind[i] == UOP_BRANCH) begin
        check_ckpt("out_ckpt_o", out_ckpt_o, exp_ckpt);
      end
    end
  endtask

  // Release old mappings, only those older than every open branch
  task automatic commit_pregs(input slot_mask_t mask);
    int safe;
    int n;
    int idx;
    safe = (ck_cnt > 0 ? ck_mark[ck_head] : pushed_total) - popped_total;
    n    = 0;
    @(negedge clk);
    for (int i = 0; i < NW; i++) begin
      commit_valid_i[i] = 1'b0;
      commit_preg_i[i]  = '0;
      if (mask[i] && n < safe) begin
        commit_valid_i[i] = 1'b1;
        commit_preg_i[i]  = retire_q.pop_front();
        popped_total++;
        n++;
        fl.push_back(commit_preg_i[i]);
        // Commits survive a rewind
        for (int c = 0; c < ck_cnt; c++) begin
          idx = (ck_head + c) % NCK;
          ck_fl[idx][ck_fl_n[idx]] = commit_preg_i[i];
          ck_fl_n[idx]++;
        end
      end
    end
    @(negedge clk);
    commit_valid_i = '0;
  endtask

  // Resolve the oldest branch
  task automatic resolve_branch(input logic mispredict);
    @(negedge clk);
    resolve_i    = 1'b1;
    mispredict_i = mispredict;
    if (mispredict) begin
      tbl = ck_tbl[ck_head];
      fl.delete();
      for (int k = 0; k < ck_fl_n[ck_head]; k++) fl.push_back(ck_fl[ck_head][k]);
      // Squashed groups never commit
      while (pushed_total > ck_mark[ck_head]) begin
        void'(retire_q.pop_back());
        pushed_total--;
      end
      ck_tail = ck_head;
      ck_cnt  = 0;
    end else begin
      ck_head = (ck_head + 1) % NCK;
      ck_cnt--;
    end
    @(negedge clk);
    resolve_i    = 1'b0;
    mispredict_i = 1'b0;
  endtask

  task automatic check_stall_held(input string why);
    repeat (3) begin
      @(negedge clk);
      if (!stall_o) stop_on_error($sformatf("stall_o went low %s", why));
    end
  endtask

  // ==============================
  // Tests
  // ==============================
  task automatic test_identity_after_reset();
    clear_group();
    for (int i = 0; i < NW; i++) set_slot(i, UOP_ALU, i + 4, i + 8, i + 12);
    issue_group();
    expect_group();
    // Literal values straight from the reset state
    for (int i = 0; i < NW; i++) begin
      check_preg($sformatf("psrc0_o[%0d]", i), psrc0_o[i], preg_t'(i + 4));
      check_preg($sformatf("ppdst_o[%0d]", i), ppdst_o[i], preg_t'(i + 12));
      check_preg($sformatf("pdst_o[%0d]", i), pdst_o[i], preg_t'(`ARCH_REG_NUM + i));
    end
  endtask

  task automatic test_in_group_forwarding();
    clear_group();
    set_slot(0, UOP_ALU, 1, 2, 3);
    set_slot(1, UOP_ALU, 3, 3, 3);
    set_slot(2, UOP_ALU, 3, 1, 7);
    issue_group();
    expect_group();
    // Next group sees only the last writer of r3
    clear_group();
    set_slot(0, UOP_ALU, 3, 7, 9);
    set_slot(2, UOP_NOP, 3, 3, 3);
    issue_group();
    expect_group();
  endtask

  task automatic test_free_list_stall();
    while (fl.size() >= NW) begin
      clear_group();
      for (int i = 0; i < NW; i++) set_slot(i, UOP_ALU, i, i + 20, i + 20);
      issue_group();
      expect_group();
    end
    clear_group();
    for (int i = 0; i < NW; i++) set_slot(i, UOP_ALU, i + 20, i, i + 24);
    issue_group();
    check_stall_held("with too few free registers");
    commit_pregs(4'b1111);
    expect_group();
  endtask

  task automatic test_mispredict_restore();
    repeat (6) commit_pregs(4'b1111);
    clear_group();
    set_slot(0, UOP_ALU, 1, 2, 10);
    set_slot(1, UOP_BRANCH, 10, 3, 0);
    set_slot(2, UOP_ALU, 10, 4, 11);
    set_slot(3, UOP_ALU, 11, 5, 10);
    issue_group();
    expect_group();
    // Wrong-path groups
    repeat (2) begin
      clear_group();
      for (int i = 0; i < NW; i++) set_slot(i, UOP_ALU, 10 + i, 11, 10 + i);
      issue_group();
      expect_group();
    end
    resolve_branch(1'b1);
    clear_group();
    set_slot(0, UOP_ALU, 10, 11, 12);
    set_slot(1, UOP_ALU, 12, 13, 11);
    issue_group();
    expect_group();
  endtask

  task automatic test_checkpoint_fifo();
    repeat (2) commit_pregs(4'b1111);
    for (int g = 0; g < NCK; g++) begin
      clear_group();
      set_slot(0, UOP_ALU, g, g + 1, g + 16);
      set_slot(1, UOP_BRANCH, g + 16, 0, 0);
      set_slot(2, UOP_ALU, g + 16, 2, g + 20);
      issue_group();
      expect_group();
    end
    // Full FIFO, plain groups still flow
    clear_group();
    set_slot(0, UOP_ALU, 16, 17, 18);
    set_slot(3, UOP_ALU, 18, 19, 21);
    issue_group();
    expect_group();
    clear_group();
    set_slot(0, UOP_BRANCH, 20, 21, 0);
    set_slot(1, UOP_ALU, 20, 21, 22);
    issue_group();
    check_stall_held("with every checkpoint in use");
    resolve_branch(1'b0);
    expect_group();
    resolve_branch(1'b0);
    resolve_branch(1'b0);
    resolve_branch(1'b1);
    clear_group();
    for (int i = 0; i < NW; i++) set_slot(i, UOP_ALU, 16 + i, 20 + i, 24 + i);
    issue_group();
    expect_group();
  endtask

  task automatic build_random_group();
    int writers;
    int r;
    logic has_branch;
    uop_kind_e k;
    writers    = 0;
    has_branch = 1'b0;
    for (int i = 0; i < NW; i++) begin
      r = $urandom % 8;
      if (r < 2) begin
        k = UOP_NOP;
      end else if (r == 2 && !has_branch && ck_cnt < NCK) begin
        k = UOP_BRANCH;
        has_branch = 1'b1;
      end else if (writers < fl.size()) begin
        k = UOP_ALU;
        writers++;
      end else begin
        k = UOP_NOP;
      end
      set_slot(i, k, $urandom % 32, $urandom % 32, $urandom % 32);
    end
  endtask

  task automatic test_random_traffic();
    for (int n = 0; n < 80; n++) begin
      if ($urandom % 2) commit_pregs(slot_mask_t'($urandom));
      if (ck_cnt > 0 && ($urandom % 3) == 0) resolve_branch(($urandom % 3) == 0);
      build_random_group();
      issue_group();
      expect_group();
    end
  endtask

  // ==============================
  // Main sequence
  // ==============================
  initial begin
    void'($urandom(32'hdbc3de93));
    s_rst_n        = 1'b0;
    group_valid_i  = 1'b0;
    src0_i         = '0;
    src1_i         = '0;
    dest_i         = '0;
    commit_valid_i = '0;
    commit_preg_i  = '0;
    resolve_i      = 1'b0;
    mispredict_i   = 1'b0;
    for (int i = 0; i < NW; i++) kind_i[i] = UOP_NOP;
    // Identity map and the upper pregs free
    for (int i = 0; i < `ARCH_REG_NUM; i++) tbl[i] = preg_t'(i);
    for (int i = 0; i < FL_DEPTH; i++) fl.push_back(preg_t'(`ARCH_REG_NUM + i));
    pushed_total = 0;
    popped_total = 0;
    ck_head      = 0;
    ck_tail      = 0;
    ck_cnt       = 0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    s_rst_n = 1'b1;

    test_identity_after_reset();
    test_in_group_forwarding();
    test_free_list_stall();
    test_mispredict_restore();
    test_checkpoint_fifo();
    test_random_traffic();

    $display("test passed");
    $finish;
  end

endmodule

// File: files.f
+incdir+verilog
verilog/rename_pkg.sv
verilog/rename_intake.sv
verilog/free_list.sv
verilog/register_alias_table.sv
verilog/rename_output.sv
verilog/rename_top.sv
bench/rename_tb.sv

// File: Bender.yml
package:
  name: rename_stage

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rename_pkg.sv
      - verilog/rename_intake.sv
      - verilog/free_list.sv
      - verilog/register_alias_table.sv
      - verilog/rename_output.sv
      - verilog/rename_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - bench/rename_tb.sv
